//--- hdl/ooo_pkg.sv
//------------------------------------------------------------
// ooo commit package
// widths, unit result structs, buffer write and retire types
//------------------------------------------------------------
package ooo_pkg;

  localparam int CB_DEPTH   = 8;  // completion buffer entries.
  localparam int PRED_IDX_W = 6;  // enough for a 64 entry table.

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [$clog2(CB_DEPTH)-1:0] cb_idx_t;
  typedef logic [PRED_IDX_W-1:0] pred_idx_t;

  // trap causes the back end can raise.
  typedef enum logic [1:0] {
    CAUSE_NONE      = 2'd0,
    CAUSE_MAL_INSN  = 2'd1,
    CAUSE_MAL_LOAD  = 2'd2,
    CAUSE_MAL_STORE = 2'd3
  } cause_t;

  typedef struct packed {
    logic     valid;
    cb_idx_t  index;     // buffer entry of the instruction.
    reg_idx_t rd;
    word_t    wdata;
    word_t    pc;
    logic     mal_addr;  // load/store only.
  } fu_result_t;

  typedef struct packed {
    fu_result_t fu;
    logic       branch_instr;
    logic       jump_instr;
    logic       prediction;     // taken as predicted at fetch.
    logic       branch_taken;
    word_t      br_resolved_addr;
    word_t      jump_addr;
  } alu_result_t;

  typedef struct packed {
    logic     ready;      // write strobe.
    cb_idx_t  index;
    reg_idx_t vd;
    word_t    wdata;      // result, redirect target or epc.
    logic     wen;
    logic     valid;      // clear means redirect.
    logic     exception;
    cause_t   cause;
  } cb_write_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t vd;
    word_t    wdata;
    logic     wen;
  } retire_t;

  typedef struct packed {
    logic  update;
    word_t pc;      // pc of the branch itself.
    logic  taken;
  } pred_update_t;

endpackage

//--- hdl/bimodal_predictor.sv
//------------------------------------------------------------
// bimodal branch predictor
// two-bit saturating counters indexed by pc, one lookup and
// one update port
//------------------------------------------------------------
`timescale 1ns/100ps

module bimodal_predictor #(
  parameter int PRED_ENTRIES = 64
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  ooo_pkg::word_t        lookup_pc,
  output logic                  predict_taken,
  input  ooo_pkg::pred_update_t pred_update
);
  import ooo_pkg::*;

  localparam int IDX_W = $clog2(PRED_ENTRIES);

  logic [1:0] cnt [PRED_ENTRIES];
  logic [1:0] cur;
  pred_idx_t  lookup_idx;
  pred_idx_t  update_idx;

  // word aligned pcs, so bits 1:0 are skipped.
  assign lookup_idx = pred_idx_t'(lookup_pc[IDX_W+1:2]);
  assign update_idx = pred_idx_t'(pred_update.pc[IDX_W+1:2]);

  assign predict_taken = cnt[lookup_idx][1];
  assign cur           = cnt[update_idx];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < PRED_ENTRIES; i++) begin
        cnt[i] <= 2'b01;  // weakly not taken.
      end
    end else if (pred_update.update) begin
      if (pred_update.taken && cur != 2'b11)
        cnt[update_idx] <= cur + 2'b01;
      else if (!pred_update.taken && cur != 2'b00)
        cnt[update_idx] <= cur - 2'b01;
    end
  end

endmodule

//--- hdl/completion_buffer.sv
//------------------------------------------------------------
// completion buffer
// circular in-order buffer, four write ports, retires one
// entry per cycle and flushes on redirect or exception
//------------------------------------------------------------
`timescale 1ns/100ps

module completion_buffer #(
  parameter int DEPTH = ooo_pkg::CB_DEPTH
) (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               halt,
  input  logic               alloc,
  output ooo_pkg::cb_idx_t   alloc_index,
  output logic               full,
  input  ooo_pkg::cb_write_t cb_a,
  input  ooo_pkg::cb_write_t cb_mu,
  input  ooo_pkg::cb_write_t cb_du,
  input  ooo_pkg::cb_write_t cb_ls,
  output ooo_pkg::retire_t   retire,
  output logic               redirect,
  output ooo_pkg::word_t     redirect_pc,
  output logic               exception,
  output ooo_pkg::cause_t    exception_cause,
  output ooo_pkg::word_t     epc,
  output logic               flush
);
  import ooo_pkg::*;

  localparam int NPORT = 4;
  localparam int CNT_W = $clog2(DEPTH) + 1;

  cb_idx_t          head;
  cb_idx_t          tail;
  cb_idx_t          head_nxt;
  cb_idx_t          tail_nxt;
  logic [CNT_W-1:0] count;
  logic [DEPTH-1:0] busy;
  logic [DEPTH-1:0] rdy;
  reg_idx_t         vd_q    [DEPTH];
  word_t            wdata_q [DEPTH];
  cause_t           cause_q [DEPTH];
  logic [DEPTH-1:0] wen_q;
  logic [DEPTH-1:0] valid_q;
  logic [DEPTH-1:0] exc_q;
  cb_write_t        wr [NPORT];
  logic             head_ready;
  logic             do_retire;
  logic             do_alloc;
  logic             clear;

  assign wr[0] = cb_a;
  assign wr[1] = cb_mu;
  assign wr[2] = cb_du;
  assign wr[3] = cb_ls;

  // wrap at DEPTH.
  assign head_nxt = (head == cb_idx_t'(DEPTH - 1)) ? '0 : head + 1'b1;
  assign tail_nxt = (tail == cb_idx_t'(DEPTH - 1)) ? '0 : tail + 1'b1;

  assign head_ready = busy[head] & rdy[head];
  assign exception  = head_ready & exc_q[head];
  assign redirect   = head_ready & ~exc_q[head] & ~valid_q[head];
  assign do_retire  = head_ready & ~exc_q[head] & valid_q[head];
  assign flush      = redirect | exception;
  assign clear      = flush | halt;

  assign retire.valid = do_retire;
  assign retire.vd    = vd_q[head];
  assign retire.wdata = wdata_q[head];
  assign retire.wen   = do_retire & wen_q[head];

  assign redirect_pc     = wdata_q[head];
  assign epc             = wdata_q[head];  // pc of the faulting instruction.
  assign exception_cause = cause_q[head];

  assign full        = (count == CNT_W'(DEPTH));
  assign alloc_index = tail;
  assign do_alloc    = alloc & ~full & ~clear;  // dispatch drops it otherwise.

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      busy  <= '0;
      rdy   <= '0;
    end else if (flush) begin
      // restart right after the trapping entry.
      head  <= head_nxt;
      tail  <= head_nxt;
      count <= '0;
      busy  <= '0;
      rdy   <= '0;
    end else if (halt) begin
      head  <= tail;
      count <= '0;
      busy  <= '0;
      rdy   <= '0;
    end else begin
      for (int p = 0; p < NPORT; p++) begin
        if (wr[p].ready)
          rdy[wr[p].index] <= 1'b1;
      end
      if (do_retire) begin
        busy[head] <= 1'b0;
        rdy[head]  <= 1'b0;
        head       <= head_nxt;
      end
      if (do_alloc) begin
        busy[tail] <= 1'b1;
        rdy[tail]  <= 1'b0;
        tail       <= tail_nxt;
      end
      count <= count + CNT_W'(do_alloc) - CNT_W'(do_retire);
    end
  end

  always_ff @(posedge CLK) begin
    for (int p = 0; p < NPORT; p++) begin
      if (wr[p].ready) begin
        vd_q[wr[p].index]    <= wr[p].vd;
        wdata_q[wr[p].index] <= wr[p].wdata;
        wen_q[wr[p].index]   <= wr[p].wen;
        valid_q[wr[p].index] <= wr[p].valid;
        exc_q[wr[p].index]   <= wr[p].exception;
        cause_q[wr[p].index] <= wr[p].cause;
      end
    end
  end

endmodule

//--- hdl/ooo_commit_stage.sv
//------------------------------------------------------------
// commit stage
// registers unit results, classifies them into completion
// buffer writes and trains the branch predictor
//------------------------------------------------------------
`timescale 1ns/100ps

module ooo_commit_stage #(
  parameter int DEPTH = ooo_pkg::CB_DEPTH
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  halt,
  input  logic                  flush,
  input  ooo_pkg::alu_result_t  alu_result,
  input  ooo_pkg::fu_result_t   mul_result,
  input  ooo_pkg::fu_result_t   div_result,
  input  ooo_pkg::fu_result_t   ls_result,
  input  logic                  ls_is_store,
  output ooo_pkg::cb_write_t    cb_a,
  output ooo_pkg::cb_write_t    cb_mu,
  output ooo_pkg::cb_write_t    cb_du,
  output ooo_pkg::cb_write_t    cb_ls,
  output ooo_pkg::pred_update_t pred_update
);
  import ooo_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);
  localparam int NFU   = 3;  // mul, div, load/store.

  logic        alu_vld;
  alu_result_t alu_q;
  fu_result_t  fu_in  [NFU];
  fu_result_t  fu_q   [NFU];
  logic        fu_vld [NFU];
  logic        store_q;
  logic        drop;
  logic        br_mispredict;
  logic        bad_target;

  // non-alu units share one classification.
  function automatic cb_write_t fu_write(input fu_result_t r, input logic vld,
                                         input logic store);
    cb_write_t w;
    w.ready     = vld;
    w.index     = cb_idx_t'(r.index[IDX_W-1:0]);
    w.vd        = r.rd;
    w.wen       = ~r.mal_addr;
    w.valid     = 1'b1;
    w.exception = r.mal_addr;
    w.wdata     = r.mal_addr ? r.pc : r.wdata;  // epc on a fault.
    if (!r.mal_addr)
      w.cause = CAUSE_NONE;
    else
      w.cause = store ? CAUSE_MAL_STORE : CAUSE_MAL_LOAD;
    return w;
  endfunction

  assign drop     = flush | halt;
  assign fu_in[0] = mul_result;
  assign fu_in[1] = div_result;
  assign fu_in[2] = ls_result;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      alu_vld <= 1'b0;
      for (int i = 0; i < NFU; i++) begin
        fu_vld[i] <= 1'b0;
      end
    end else begin
      alu_vld <= alu_result.fu.valid & ~drop;  // younger results die on flush.
      for (int i = 0; i < NFU; i++) begin
        fu_vld[i] <= fu_in[i].valid & ~drop;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (alu_result.fu.valid)
      alu_q <= alu_result;
    for (int i = 0; i < NFU; i++) begin
      if (fu_in[i].valid)
        fu_q[i] <= fu_in[i];
    end
    if (ls_result.valid)
      store_q <= ls_is_store;
  end

  assign br_mispredict = alu_q.branch_instr & (alu_q.prediction ^ alu_q.branch_taken);
  assign bad_target    = (alu_q.jump_instr & (alu_q.jump_addr[1:0] != 2'b00)) |
                         (alu_q.branch_instr & (alu_q.br_resolved_addr[1:0] != 2'b00));

  always_comb begin
    cb_a.ready     = alu_vld;
    cb_a.index     = cb_idx_t'(alu_q.fu.index[IDX_W-1:0]);
    cb_a.vd        = alu_q.fu.rd;
    cb_a.wdata     = alu_q.fu.wdata;
    cb_a.wen       = 1'b1;
    cb_a.valid     = 1'b1;
    cb_a.exception = 1'b0;
    cb_a.cause     = CAUSE_NONE;
    if (bad_target) begin
      cb_a.exception = 1'b1;
      cb_a.cause     = CAUSE_MAL_INSN;
      cb_a.wdata     = alu_q.fu.pc;
      cb_a.wen       = 1'b0;
    end else if (br_mispredict) begin
      cb_a.valid = 1'b0;
      cb_a.wdata = alu_q.br_resolved_addr;
      cb_a.wen   = 1'b0;
    end else if (alu_q.jump_instr) begin
      cb_a.valid = 1'b0;  // every jump redirects.
      cb_a.wdata = alu_q.jump_addr;
      cb_a.wen   = 1'b0;
    end else if (alu_q.branch_instr) begin
      cb_a.wen = 1'b0;  // correct guess, nothing to write.
    end
  end

  assign cb_mu = fu_write(fu_q[0], fu_vld[0], 1'b0);
  assign cb_du = fu_write(fu_q[1], fu_vld[1], 1'b0);
  assign cb_ls = fu_write(fu_q[2], fu_vld[2], store_q);

  assign pred_update.update = alu_vld & alu_q.branch_instr;
  assign pred_update.pc     = alu_q.fu.pc;
  assign pred_update.taken  = alu_q.branch_taken;

endmodule

//--- hdl/ooo_commit_top.sv
//------------------------------------------------------------
// ooo commit top
// commit stage, completion buffer and branch predictor
//------------------------------------------------------------
`timescale 1ns/100ps

module ooo_commit_top #(
  parameter int DEPTH        = ooo_pkg::CB_DEPTH,
  parameter int PRED_ENTRIES = 64
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 halt,
  input  logic                 alloc,
  output ooo_pkg::cb_idx_t     alloc_index,
  output logic                 full,
  input  ooo_pkg::alu_result_t alu_result,
  input  ooo_pkg::fu_result_t  mul_result,
  input  ooo_pkg::fu_result_t  div_result,
  input  ooo_pkg::fu_result_t  ls_result,
  input  logic                 ls_is_store,
  input  ooo_pkg::word_t       lookup_pc,
  output logic                 predict_taken,
  output ooo_pkg::retire_t     retire,
  output logic                 redirect,
  output ooo_pkg::word_t       redirect_pc,
  output logic                 exception,
  output ooo_pkg::cause_t      exception_cause,
  output ooo_pkg::word_t       epc
);
  import ooo_pkg::*;

  cb_write_t    cb_a;
  cb_write_t    cb_mu;
  cb_write_t    cb_du;
  cb_write_t    cb_ls;
  pred_update_t pred_update;
  logic         flush;

  ooo_commit_stage #(.DEPTH(DEPTH)) u_commit (
    .CLK, .nRST, .halt, .flush,
    .alu_result, .mul_result, .div_result, .ls_result, .ls_is_store,
    .cb_a, .cb_mu, .cb_du, .cb_ls,
    .pred_update
  );

  completion_buffer #(.DEPTH(DEPTH)) u_cb (
    .CLK, .nRST, .halt, .alloc, .alloc_index, .full,
    .cb_a, .cb_mu, .cb_du, .cb_ls,
    .retire, .redirect, .redirect_pc,
    .exception, .exception_cause, .epc,
    .flush  // back to the commit registers.
  );

  bimodal_predictor #(.PRED_ENTRIES(PRED_ENTRIES)) u_pred (
    .CLK, .nRST,
    .lookup_pc, .predict_taken,
    .pred_update
  );

endmodule

//--- verif/tb_ooo_model.svh
//------------------------------------------------------------
// testbench model
// expected retirement queue, predictor counters, lcg source
//------------------------------------------------------------
`ifndef TB_OOO_MODEL_SVH
`define TB_OOO_MODEL_SVH

  localparam logic [2:0] K_NORM   = 3'd0;
  localparam logic [2:0] K_BR_OK  = 3'd1;
  localparam logic [2:0] K_BR_MIS = 3'd2;
  localparam logic [2:0] K_JUMP   = 3'd3;
  localparam logic [2:0] K_BAD_J  = 3'd4;
  localparam logic [2:0] K_BAD_BR = 3'd5;
  localparam logic [2:0] K_MAL_LS = 3'd6;

  typedef struct packed {
    logic [2:0] kind;
    logic [1:0] unit;       // 0 alu, 1 mul, 2 div, 3 load/store.
    cb_idx_t    idx;
    reg_idx_t   rd;
    word_t      data;
    word_t      pc;
    word_t      target;     // branch or jump destination.
    logic       taken;
    logic       pred;
    logic       store;
    logic [1:0] ev;         // 0 retire, 1 redirect, 2 exception.
    word_t      exp_data;
    logic       exp_wen;
    cause_t     exp_cause;
  } entry_t;

  entry_t      exp_q [$];  // outstanding entries in program order.
  logic [1:0]  ctr_m [64];
  cb_idx_t     tail_m;
  logic [31:0] rng_state = 32'd30912;
  int          checks;
  int          errors;
  int          timeouts;

  function automatic logic [15:0] lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[31:16];  // low bits repeat too soon.
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    return lcg_next() % n;
  endfunction

  function automatic word_t rnd_word();
    return {lcg_next(), lcg_next()};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // two-bit saturating counter per word-aligned pc.
  function automatic void train_counter(input word_t pc, input logic taken);
    logic [5:0] i;
    i = pc[7:2];
    if (taken && ctr_m[i] != 2'b11)
      ctr_m[i] = ctr_m[i] + 2'b01;
    else if (!taken && ctr_m[i] != 2'b00)
      ctr_m[i] = ctr_m[i] - 2'b01;
  endfunction

  function automatic entry_t make_entry(input cb_idx_t idx);
    entry_t      e;
    int unsigned r;
    e        = '0;
    e.idx    = idx;
    e.rd     = reg_idx_t'(pick(32));
    e.data   = rnd_word();
    e.pc     = 32'h1000 + (pick(16) << 2);
    e.target = rnd_word() & 32'hffff_fffc;
    e.taken  = 1'(pick(2));
    e.store  = 1'(pick(2));
    r = pick(32);
    if (r < 20 || r == 31)
      e.kind = K_NORM;
    else if (r < 26)
      e.kind = K_BR_OK;
    else
      e.kind = 3'(r - 24);  // one of each trapping kind.
    if (e.kind == K_NORM)
      e.unit = 2'(pick(4));
    else
      e.unit = (e.kind == K_MAL_LS) ? 2'd3 : 2'd0;
    e.pred      = (e.kind == K_BR_MIS) ? ~e.taken : e.taken;
    e.exp_data  = e.data;
    e.exp_wen   = 1'b1;
    e.exp_cause = CAUSE_NONE;
    case (e.kind)
      K_BR_OK: e.exp_wen = 1'b0;
      K_BR_MIS, K_JUMP: begin
        e.ev       = 2'd1;
        e.exp_data = e.target;
      end
      K_BAD_J, K_BAD_BR: begin
        e.target[1:0] = 2'(1 + pick(3));
        e.ev          = 2'd2;
        e.exp_data    = e.pc;
        e.exp_cause   = CAUSE_MAL_INSN;
      end
      K_MAL_LS: begin
        e.ev        = 2'd2;
        e.exp_data  = e.pc;
        e.exp_cause = e.store ? CAUSE_MAL_STORE : CAUSE_MAL_LOAD;
      end
      default: ;
    endcase
    return e;
  endfunction

`endif

//--- verif/tb_ooo_commit.sv
//------------------------------------------------------------
// testbench for the ooo commit back end
// random batches checked against an in-order model
//------------------------------------------------------------
`timescale 1ns/100ps

module tb_ooo_commit;
  import ooo_pkg::*;

  logic        CLK;
  logic        nRST;
  logic        halt;
  logic        alloc;
  cb_idx_t     alloc_index;
  logic        full;
  alu_result_t alu_result;
  fu_result_t  mul_result;
  fu_result_t  div_result;
  fu_result_t  ls_result;
  logic        ls_is_store;
  word_t       lookup_pc;
  logic        predict_taken;
  retire_t     retire;
  logic        redirect;
  word_t       redirect_pc;
  logic        exception;
  cause_t      exception_cause;
  word_t       epc;
  logic        timed_out;

`include "tb_ooo_model.svh"

  entry_t prog [$];  // current batch in program order.

  ooo_commit_top #(.DEPTH(CB_DEPTH), .PRED_ENTRIES(64)) dut (.*);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(negedge CLK) begin : monitor
    entry_t     e;
    logic [2:0] want;
    if (nRST && (retire.valid || redirect || exception)) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("retirement event at %0t with no entry outstanding", $time);
      end else begin
        e    = exp_q.pop_front();
        want = (e.ev == 2'd0) ? 3'b100 : (e.ev == 2'd1) ? 3'b010 : 3'b001;
        check_val("retire/redirect/exception", {retire.valid, redirect, exception}, want);
        case (e.ev)
          2'd0: begin
            check_val("retire.vd", retire.vd, e.rd);
            check_val("retire.wdata", retire.wdata, e.exp_data);
            check_val("retire.wen", retire.wen, e.exp_wen);
          end
          2'd1: check_val("redirect_pc", redirect_pc, e.exp_data);
          default: begin
            check_val("exception_cause", exception_cause, e.exp_cause);
            check_val("epc", epc, e.exp_data);
          end
        endcase
        if (e.ev != 2'd0) begin
          exp_q.delete();  // younger entries are gone.
          tail_m = e.idx + 1'b1;
        end
      end
    end
  end

  task automatic alloc_entries(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge CLK);
      alloc <= 1'b1;
      @(negedge CLK);
      check_val("alloc_index", alloc_index, tail_m);
      check_val("full", full, exp_q.size() == 8);
      if (exp_q.size() < 8) begin
        exp_q.push_back(make_entry(tail_m));
        prog.push_back(exp_q[$]);
        tail_m++;
      end
    end
    @(posedge CLK);
    alloc <= 1'b0;
    @(negedge CLK);
    check_val("alloc_index", alloc_index, tail_m);
    check_val("full", full, exp_q.size() == 8);
  endtask

  task automatic drive_result(input entry_t e);
    alu_result_t a;
    fu_result_t  f;
    a = '0;
    f = '0;
    f.index    = e.idx;
    f.rd       = e.rd;
    f.wdata    = e.data;
    f.pc       = e.pc;
    f.mal_addr = (e.kind == K_MAL_LS);
    a.fu       = f;
    a.fu.valid = (e.unit == 2'd0);
    a.branch_instr = (e.kind == K_BR_OK) || (e.kind == K_BR_MIS) || (e.kind == K_BAD_BR);
    a.jump_instr   = (e.kind == K_JUMP) || (e.kind == K_BAD_J);
    a.prediction   = e.pred;
    a.branch_taken = e.taken;
    a.br_resolved_addr = a.branch_instr ? e.target : 32'h0;
    a.jump_addr        = a.jump_instr ? e.target : 32'h0;
    if (a.branch_instr)
      train_counter(e.pc, e.taken);
    @(posedge CLK);
    alu_result  <= a;
    f.valid      = (e.unit == 2'd1);
    mul_result  <= f;
    f.valid      = (e.unit == 2'd2);
    div_result  <= f;
    f.valid      = (e.unit == 2'd3);
    ls_result   <= f;
    ls_is_store <= e.store;
  endtask

  task automatic idle_units();
    @(posedge CLK);
    alu_result.fu.valid <= 1'b0;
    mul_result.valid    <= 1'b0;
    div_result.valid    <= 1'b0;
    ls_result.valid     <= 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 200) begin
      @(posedge CLK);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d entries still outstanding after 200 cycles", exp_q.size());
      timeouts++;
      timed_out = 1'b1;
    end
  endtask

  task automatic check_quiet(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge CLK);
      check_val("retire.valid", retire.valid, 1'b0);
      check_val("redirect", redirect, 1'b0);
      check_val("exception", exception, 1'b0);
      check_val("full", full, 1'b0);
    end
  endtask

  task automatic check_predictor(input int n);
    word_t pc;
    for (int i = 0; i < n; i++) begin
      pc = 32'h1000 + i * 4;
      @(posedge CLK);
      lookup_pc <= pc;
      @(negedge CLK);
      check_val("predict_taken", predict_taken, ctr_m[pc[7:2]][1]);
    end
  endtask

  task automatic halt_buffer();
    prog.delete();
    alloc_entries(1 + pick(4));
    // head result goes last and is still in flight when halt hits.
    for (int i = prog.size() - 1; i >= 0; i--)
      drive_result(prog[i]);
    idle_units();
    halt <= 1'b1;
    exp_q.delete();
    @(posedge CLK);
    halt <= 1'b0;
    check_quiet(3);
  endtask

  task automatic run_batch(input int n);
    entry_t order [$];
    entry_t tmp;
    int     j;
    int     fidx;
    prog.delete();
    alloc_entries((n == 8) ? 9 : n);  // ninth alloc hits a full buffer.
    order = prog;
    fidx  = -1;
    foreach (prog[i])
      if (fidx < 0 && prog[i].ev != 2'd0)
        fidx = i;
    for (int i = order.size() - 1; i > 0; i--) begin
      j        = pick(i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    // oldest trap issues last so every branch trains the counters
    if (fidx >= 0) begin
      for (int i = 0; i < order.size(); i++) begin
        if (order[i].idx == prog[fidx].idx) begin
          tmp = order[i];
          order.delete(i);
          order.push_back(tmp);
          break;
        end
      end
    end
    foreach (order[i]) begin
      drive_result(order[i]);
      if (pick(4) == 0)
        idle_units();
    end
    idle_units();
    wait_drain();
    if (!timed_out)
      check_predictor(16);
  endtask

  initial begin
    nRST        = 1'b0;
    halt        = 1'b0;
    alloc       = 1'b0;
    alu_result  = '0;
    mul_result  = '0;
    div_result  = '0;
    ls_result   = '0;
    ls_is_store = 1'b0;
    lookup_pc   = '0;
    timed_out   = 1'b0;
    tail_m      = '0;
    for (int i = 0; i < 64; i++)
      ctr_m[i] = 2'b01;
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    check_quiet(4);
    check_predictor(64);
    for (int b = 0; b < 48 && !timed_out; b++) begin
      if (b % 12 == 6)
        halt_buffer();
      run_batch((b % 8 == 7) ? 8 : 1 + pick(7));
    end
    $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- all.f
hdl/ooo_pkg.sv
hdl/bimodal_predictor.sv
hdl/completion_buffer.sv
hdl/ooo_commit_stage.sv
hdl/ooo_commit_top.sv
+incdir+verif
verif/tb_ooo_commit.sv

//--- Bender.yml
package:
  name: ooo_commit

sources:
  - files:
      - hdl/ooo_pkg.sv
      - hdl/bimodal_predictor.sv
      - hdl/completion_buffer.sv
      - hdl/ooo_commit_stage.sv
      - hdl/ooo_commit_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_ooo_commit.sv
